// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_brisc_mem
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing
PASS_TEXT ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+include
hw/brisc_mem_pkg.sv
hw/brisc_core_pkg.sv
hw/nff.sv
hw/memory.sv
hw/dcache.sv
hw/brisc_mem_top.sv
test/tb_brisc_mem.sv

// ==== hw/brisc_core_pkg.sv ====
`include "brisc_defines.svh"

package brisc_core_pkg;

  // address split used by the cache
  localparam int unsigned BYTE_OFF_W = $clog2(`BRISC_WORD_WIDTH / `BRISC_BYTE_WIDTH);
  localparam int unsigned WORD_OFF_W = $clog2(`BRISC_WORDS_PER_LINE);
  localparam int unsigned INDEX_W = $clog2(`BRISC_CACHE_SETS);
  localparam int unsigned TAG_W = `BRISC_ADDR_WIDTH - INDEX_W - WORD_OFF_W - BYTE_OFF_W;

  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    logic [INDEX_W-1:0]    index;
    logic [WORD_OFF_W-1:0] word_off;
    logic [BYTE_OFF_W-1:0] byte_off;
  } addr_fields_t;

  // same address word, either flat or split into cache fields
  typedef union packed {
    logic [`BRISC_ADDR_WIDTH-1:0] raw;
    addr_fields_t                 fields;
  } cache_addr_u;

  // word request from the core, held stable while req is high
  typedef struct packed {
    logic [`BRISC_ADDR_WIDTH-1:0] addr;
    logic                         write;
    logic [`BRISC_WORD_WIDTH-1:0] wdata;
  } core_req_t;

  // load data, valid together with ack
  typedef struct packed {
    logic [`BRISC_WORD_WIDTH-1:0] rdata;
  } core_resp_t;

endpackage

// ==== hw/brisc_mem_pkg.sv ====
`include "brisc_defines.svh"

package brisc_mem_pkg;

  // line request from the cache
  // addr is line aligned, data only meaningful when store is set
  typedef struct packed {
    logic [`BRISC_ADDR_WIDTH-1:0] addr;
    logic                         store;
    logic                         valid;
    logic [`BRISC_LINE_WIDTH-1:0] data;
  } line_req_t;

  // line returned by memory after a load request
  // valid is a single cycle pulse
  typedef struct packed {
    logic [`BRISC_ADDR_WIDTH-1:0] addr;
    logic                         valid;
    logic [`BRISC_LINE_WIDTH-1:0] data;
  } line_fill_t;

endpackage

// ==== hw/brisc_mem_top.sv ====
`timescale 1ns/1ps

module brisc_mem_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req,
  input  brisc_core_pkg::core_req_t  core_req,
  output logic                       ack,
  output brisc_core_pkg::core_resp_t core_resp
);

  // line traffic between cache and memory
  brisc_mem_pkg::line_req_t  line_req;
  brisc_mem_pkg::line_fill_t line_fill;

  dcache dcache0 (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .core_req (core_req),
    .ack      (ack),
    .core_resp(core_resp),
    .line_req (line_req),
    .line_fill(line_fill)
  );

  memory memory0 (
    .clk      (clk),
    .reset    (reset),
    .line_req (line_req),
    .line_fill(line_fill)
  );

endmodule

// ==== hw/dcache.sv ====
`timescale 1ns/1ps
`include "brisc_defines.svh"

module dcache (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req,
  input  brisc_core_pkg::core_req_t core_req,
  output logic                      ack,
  output brisc_core_pkg::core_resp_t core_resp,
  output brisc_mem_pkg::line_req_t  line_req,
  input  brisc_mem_pkg::line_fill_t line_fill
);

  localparam int unsigned WW = `BRISC_WORD_WIDTH;
  localparam int unsigned LW = `BRISC_LINE_WIDTH;
  localparam int unsigned SETS = `BRISC_CACHE_SETS;
  localparam int unsigned TAG_W = brisc_core_pkg::TAG_W;
  localparam int unsigned INDEX_W = brisc_core_pkg::INDEX_W;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_EVICT,
    S_FILL_WAIT,
    S_RESPOND,
    S_ACK_HOLD
  } state_t;

  state_t state_q;

  // request latched when req is first seen
  brisc_core_pkg::core_req_t req_q;
  logic [WW-1:0]             rdata_q;

  logic [LW-1:0]    data_q [SETS];
  logic [TAG_W-1:0] tag_q [SETS];
  logic [SETS-1:0]  valid_q;
  logic [SETS-1:0]  dirty_q;

  brisc_core_pkg::cache_addr_u cur_addr;
  brisc_core_pkg::cache_addr_u line_addr;
  brisc_core_pkg::cache_addr_u evict_addr;
  brisc_core_pkg::cache_addr_u fill_addr;

  logic [INDEX_W-1:0] idx;
  logic [INDEX_W-1:0] fill_idx;
  logic               hit;
  logic               victim_dirty;
  logic [LW-1:0]      fill_line;

  assign cur_addr.raw = req_q.addr;
  assign idx = cur_addr.fields.index;
  assign hit = valid_q[idx] && (tag_q[idx] == cur_addr.fields.tag);
  assign victim_dirty = valid_q[idx] && dirty_q[idx];

  assign fill_addr.raw = line_fill.addr;
  assign fill_idx = fill_addr.fields.index;

  // line aligned addresses for the fetch and for the victim
  always_comb begin
    line_addr = cur_addr;
    line_addr.fields.word_off = '0;
    line_addr.fields.byte_off = '0;
    evict_addr = line_addr;
    evict_addr.fields.tag = tag_q[idx];
  end

  // memory request pulses, store of victim first when dirty
  always_comb begin
    line_req = '0;
    if (state_q == S_LOOKUP && !hit) begin
      line_req.valid = 1'b1;
      if (victim_dirty) begin
        line_req.store = 1'b1;
        line_req.addr = evict_addr.raw;
        line_req.data = data_q[idx];
      end else begin
        line_req.addr = line_addr.raw;
      end
    end else if (state_q == S_EVICT) begin
      line_req.valid = 1'b1;
      line_req.addr = line_addr.raw;
    end
  end

  // pending store goes into the incoming line
  always_comb begin
    fill_line = line_fill.data;
    if (req_q.write) begin
      fill_line[cur_addr.fields.word_off*WW +: WW] = req_q.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= S_IDLE;
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (req) begin
            state_q <= S_LOOKUP;
          end
        end
        S_LOOKUP: begin
          if (hit) begin
            if (req_q.write) begin
              dirty_q[idx] <= 1'b1;
            end
            state_q <= S_RESPOND;
          end else if (victim_dirty) begin
            state_q <= S_EVICT;
          end else begin
            state_q <= S_FILL_WAIT;
          end
        end
        S_EVICT: begin
          state_q <= S_FILL_WAIT;
        end
        S_FILL_WAIT: begin
          if (line_fill.valid) begin
            valid_q[fill_idx] <= 1'b1;
            dirty_q[fill_idx] <= req_q.write;
            state_q <= S_RESPOND;
          end
        end
        S_RESPOND: begin
          // requester holds req until it sees ack
          state_q <= S_ACK_HOLD;
        end
        S_ACK_HOLD: begin
          if (!req) begin
            state_q <= S_IDLE;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // line data, tags and response word
  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && req) begin
      req_q <= core_req;
    end
    if (state_q == S_LOOKUP && hit) begin
      rdata_q <= data_q[idx][cur_addr.fields.word_off*WW +: WW];
      if (req_q.write) begin
        data_q[idx][cur_addr.fields.word_off*WW +: WW] <= req_q.wdata;
      end
    end
    if (state_q == S_FILL_WAIT && line_fill.valid) begin
      data_q[fill_idx] <= fill_line;
      tag_q[fill_idx] <= fill_addr.fields.tag;
      rdata_q <= fill_line[cur_addr.fields.word_off*WW +: WW];
    end
  end

  assign ack = (state_q == S_RESPOND) || (state_q == S_ACK_HOLD);
  assign core_resp.rdata = rdata_q;

endmodule

// ==== hw/memory.sv ====
`timescale 1ns/1ps
`include "brisc_defines.svh"

module memory (
  input  logic                      clk,
  input  logic                      reset,
  input  brisc_mem_pkg::line_req_t  line_req,
  output brisc_mem_pkg::line_fill_t line_fill
);

  localparam int unsigned MEM_LINES = `BRISC_MEM_DEPTH / `BRISC_WORDS_PER_LINE;
  localparam int unsigned LINE_BITS = $clog2(MEM_LINES);
  localparam int unsigned LINE_LSB = brisc_core_pkg::WORD_OFF_W + brisc_core_pkg::BYTE_OFF_W;

  // storage is kept one line per entry
  logic [`BRISC_LINE_WIDTH-1:0] mem_q [MEM_LINES];

  brisc_core_pkg::cache_addr_u rd_addr;
  brisc_core_pkg::cache_addr_u wr_addr;
  logic [LINE_BITS-1:0]        rd_line;
  logic [LINE_BITS-1:0]        wr_line;

  brisc_mem_pkg::line_req_t  req_dly;
  brisc_mem_pkg::line_fill_t fill_now;

  initial begin
    for (int i = 0; i < MEM_LINES; i++) begin
      mem_q[i] = '0;
    end
  end

  // upper address bits beyond the array wrap around
  assign rd_addr.raw = line_req.addr;
  assign rd_line = rd_addr.raw[LINE_LSB +: LINE_BITS];

  assign wr_addr.raw = req_dly.addr;
  assign wr_line = wr_addr.raw[LINE_LSB +: LINE_BITS];

  // inbound path, stores reach the array after the transfer delay
  nff #(
    .N    (`BRISC_MEM_DELAY),
    .WIDTH($bits(brisc_mem_pkg::line_req_t))
  ) way_in (
    .clk   (clk),
    .reset (reset),
    .enable(1'b1),
    .inp   (line_req),
    .out   (req_dly)
  );

  always @(posedge clk) begin
    if (req_dly.valid && req_dly.store) begin
      mem_q[wr_line] <= req_dly.data;
    end
  end

  // load data is taken in the request cycle
  always_comb begin
    fill_now.addr = line_req.addr;
    fill_now.valid = line_req.valid && !line_req.store;
    fill_now.data = mem_q[rd_line];
  end

  // return path covers both directions of travel
  nff #(
    .N    (2 * `BRISC_MEM_DELAY),
    .WIDTH($bits(brisc_mem_pkg::line_fill_t))
  ) way_back (
    .clk   (clk),
    .reset (reset),
    .enable(1'b1),
    .inp   (fill_now),
    .out   (line_fill)
  );

endmodule

// ==== hw/nff.sv ====
`timescale 1ns/1ps

module nff #(
  parameter int unsigned N = 1,
  parameter int unsigned WIDTH = 1
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             enable,
  input  logic [WIDTH-1:0] inp,
  output logic [WIDTH-1:0] out
);

  // stage 0 takes the input, stage N-1 drives the output
  logic [WIDTH-1:0] stage_q [N];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < N; i++) begin
        stage_q[i] <= '0;
      end
    end else if (enable) begin
      stage_q[0] <= inp;
      // every stage moves on together, so several items can be in flight
      for (int i = 1; i < N; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign out = stage_q[N-1];

endmodule

// ==== include/brisc_defines.svh ====
`ifndef BRISC_DEFINES_SVH
`define BRISC_DEFINES_SVH

// byte address seen by the core
`define BRISC_ADDR_WIDTH 16

// data word moved by a load or store
`define BRISC_WORD_WIDTH 32

`define BRISC_BYTE_WIDTH 8

// one cache line, moved whole between cache and memory
`define BRISC_LINE_WIDTH 128

`define BRISC_WORDS_PER_LINE (`BRISC_LINE_WIDTH / `BRISC_WORD_WIDTH)

// direct mapped, one line per set
`define BRISC_CACHE_SETS 16

// main memory size in words
`define BRISC_MEM_DEPTH 1024

// cycles spent in each direction between cache and array
`define BRISC_MEM_DELAY 4

`endif

// ==== test/tb_brisc_mem.sv ====
`timescale 1ns/1ps
`include "brisc_defines.svh"

module tb_brisc_mem;

  localparam int RESET_CYCLES = 5;
  localparam int NUM_RANDOM = 300;
  localparam int NUM_DIRECTED = 14;
  localparam int CYCLES_PER_OP = 4 * `BRISC_MEM_DELAY + 10;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + (NUM_DIRECTED + NUM_RANDOM) * CYCLES_PER_OP;
  localparam int WIDX_W = $clog2(`BRISC_MEM_DEPTH);
  localparam int BOFF_W = brisc_core_pkg::BYTE_OFF_W;

  logic                       clk;
  logic                       reset;
  logic                       req;
  brisc_core_pkg::core_req_t  core_req;
  logic                       ack;
  brisc_core_pkg::core_resp_t core_resp;

  // expected memory contents, one entry per word
  logic [`BRISC_WORD_WIDTH-1:0] shadow [`BRISC_MEM_DEPTH];
  logic [15:0]                  lfsr_q;

  // state of the access in flight, read by the compare process
  string                      cur_name;
  bit                         expect_load;
  brisc_core_pkg::core_resp_t exp_resp;
  int                         loads_issued;
  int                         loads_checked;

  logic cmp_ack;
  logic mon_req;
  logic mon_ack;

  brisc_mem_top dut0 (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .core_req (core_req),
    .ack      (ack),
    .core_resp(core_resp)
  );

  always #4 clk = ~clk;

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_rdata(input string name, input brisc_core_pkg::core_resp_t expected,
                             input brisc_core_pkg::core_resp_t actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", name, expected.rdata, actual.rdata);
      abort_run();
    end
  endtask

  task automatic check_ack(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
      $display("Fail %s: expected ack %b, actual ack %b", name, expected, actual);
      abort_run();
    end
  endtask

  // 16 bit fibonacci lfsr, taps 16 14 13 11, one step per bit
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // a load sees the last word stored at its address, zero if none
  function automatic logic [`BRISC_WORD_WIDTH-1:0] ref_read(
    input logic [`BRISC_ADDR_WIDTH-1:0] addr
  );
    return shadow[addr[BOFF_W +: WIDX_W]];
  endfunction

  // four-phase access, req held for hold extra cycles after ack
  task automatic do_access(input string name, input logic [`BRISC_ADDR_WIDTH-1:0] addr,
                           input logic write, input logic [`BRISC_WORD_WIDTH-1:0] wdata,
                           input int hold);
    brisc_core_pkg::core_req_t r;
    r.addr = addr;
    r.write = write;
    r.wdata = wdata;
    cur_name = name;
    if (write) begin
      shadow[addr[BOFF_W +: WIDX_W]] = wdata;
    end else begin
      exp_resp.rdata = ref_read(addr);
      expect_load = 1'b1;
      loads_issued++;
    end
    @(posedge clk);
    #1;
    core_req = r;
    req = 1'b1;
    @(negedge clk);
    while (ack !== 1'b1) @(negedge clk);
    repeat (hold) @(posedge clk);
    @(posedge clk);
    #1;
    req = 1'b0;
    @(negedge clk);
    while (ack !== 1'b0) @(negedge clk);
    expect_load = 1'b0;
  endtask

  // compare process, load data checked as ack rises
  always @(negedge clk) begin
    if (ack === 1'b1 && cmp_ack === 1'b0 && expect_load) begin
      check_rdata(cur_name, exp_resp, core_resp);
      loads_checked++;
    end
    cmp_ack = ack;
  end

  // handshake rules, checked every cycle
  always @(negedge clk) begin
    if (!mon_req && mon_ack) begin
      check_ack("ack_drop_after_req", 1'b0, ack);
    end else if (mon_req && mon_ack && req) begin
      check_ack("ack_hold_while_req", 1'b1, ack);
    end else if (!mon_ack && !req) begin
      check_ack("ack_without_req", 1'b0, ack);
    end
    mon_req = req;
    mon_ack = ack;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles, an access never completed", WATCHDOG_CYCLES);
    abort_run();
  end

  initial begin
    logic [31:0]                  r;
    logic                         is_write;
    logic [`BRISC_ADDR_WIDTH-1:0] addr;
    logic [`BRISC_WORD_WIDTH-1:0] wdata;
    clk = 1'b0;
    reset = 1'b1;
    req = 1'b0;
    core_req = '0;
    lfsr_q = 16'd29;
    expect_load = 1'b0;
    exp_resp = '0;
    loads_issued = 0;
    loads_checked = 0;
    cmp_ack = 1'b0;
    mon_req = 1'b0;
    mon_ack = 1'b0;
    for (int i = 0; i < `BRISC_MEM_DEPTH; i++) begin
      shadow[i] = '0;
    end

    // reset state
    for (int i = 0; i < RESET_CYCLES - 1; i++) begin
      @(negedge clk);
      check_ack("reset_ack", 1'b0, ack);
    end
    @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_ack("ack_after_reset", 1'b0, ack);
    do_access("first_load_a", 16'h0ab8, 1'b0, '0, 0);
    do_access("first_load_b", 16'h0040, 1'b0, '0, 0);

    // store then load, miss and hit
    do_access("store_miss", 16'h0100, 1'b1, 32'hdeadbeef, 0);
    do_access("load_hit", 16'h0100, 1'b0, '0, 0);
    do_access("store_same_set", 16'h0200, 1'b1, 32'h12345678, 0);
    do_access("load_miss", 16'h0100, 1'b0, '0, 0);
    do_access("load_hit_again", 16'h0100, 1'b0, '0, 0);

    // conflict eviction, same index and different tag
    do_access("store_a", 16'h0014, 1'b1, 32'h0badf00d, 0);
    do_access("store_b", 16'h0314, 1'b1, 32'hcafe0001, 0);
    do_access("load_a_evicted", 16'h0014, 1'b0, '0, 0);
    do_access("load_b_evicted", 16'h0314, 1'b0, '0, 0);

    // handshake with req held past ack
    do_access("load_held", 16'h0314, 1'b0, '0, 3);
    do_access("store_held", 16'h0318, 1'b1, 32'h5a5aa5a5, 2);
    do_access("load_after_held", 16'h0318, 1'b0, '0, 0);

    // random traffic over 64 lines
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = random_bits(1);
      is_write = r[0];
      r = random_bits(8);
      addr = {6'b0, r[7:0], 2'b00};
      wdata = '0;
      if (is_write) begin
        wdata = random_bits(32);
      end
      do_access($sformatf("random_%0d", n), addr, is_write, wdata, 0);
    end

    @(negedge clk);
    if (loads_checked != loads_issued) begin
      $display("only %0d of %0d load responses were compared", loads_checked, loads_issued);
      abort_run();
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule
